// File: filelist.f
rv_pkg.sv
rv_decoder.sv
rv_imm_gen.sv
rv_execute.sv
rv_regfile.sv
rv_pc_counter.sv
rv_core_fsm.sv
rv_core_top.sv
tb_rv_core.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the core testbench with Verilator, result decided from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_rv_core -f filelist.f \
    && ./obj_dir/Vtb_rv_core 2>&1 | tee sim.log
grep -q "TESTBENCH PASSED" sim.log \
    && echo "run.sh: simulation ok" \
    || { echo "run.sh: simulation did not pass"; exit 1; }

// File: rv_core_fsm.sv
module rv_core_fsm import rv_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic [XLEN-1:0] imem_rdata,
    input  logic [XLEN-1:0] pc,
    input  ctrl_t           ctrl,
    input  logic            is_illegal,
    input  logic            is_ebreak,
    input  logic [XLEN-1:0] result,
    input  logic            pc_load,
    input  logic [XLEN-1:0] pc_target,
    output logic [XLEN-1:0] ir,            // instruction register
    output logic            advance,       // retire pulse in WB
    output logic            pc_load_q,
    output logic [XLEN-1:0] pc_target_q,
    output commit_t         commit,
    output logic            halted,
    output logic            illegal        // halt cause was an illegal instruction
);

    state_e          state;
    state_e          state_nxt;
    logic [XLEN-1:0] result_q;
    logic            stop;

    assign stop = is_illegal || is_ebreak;

    always_comb begin
        case (state)
            ST_FETCH: state_nxt = ST_EXEC;
            ST_EXEC:  state_nxt = stop ? ST_HALT : ST_WB;
            ST_WB:    state_nxt = ST_FETCH;
            default:  state_nxt = ST_HALT;   // stays until reset
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ST_FETCH;
            ir        <= '0;
            pc_load_q <= 1'b0;
            illegal   <= 1'b0;
        end else begin
            state <= state_nxt;
            if (state == ST_FETCH) begin
                ir <= imem_rdata;   // memory answers within the cycle
            end
            if (state == ST_EXEC) begin
                pc_load_q <= pc_load;
                if (is_illegal) begin
                    illegal <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_EXEC) begin
            result_q    <= result;
            pc_target_q <= pc_target;
        end
    end

    assign advance = (state == ST_WB);
    assign halted  = (state == ST_HALT);

    always_comb begin
        commit.valid = advance;
        commit.pc    = pc;          // pc only moves at the end of WB
        commit.inst  = ir;
        commit.wen   = ctrl.reg_wen;
        commit.waddr = ctrl.reg_waddr;
        commit.wdata = result_q;
    end

    // commit.pc relies on the counter moving only on the retire pulse
    pc_held: assert property (
        @(posedge clk) disable iff (!rst_n)
        !advance |=> $stable(pc)
    ) else $error("pc moved outside of writeback");

    commit_not_halting: assert property (
        @(posedge clk) disable iff (!rst_n)
        commit.valid |-> !stop
    ) else $error("retired an illegal or ebreak instruction");

endmodule

// File: rv_core_top.sv
module rv_core_top import rv_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = '0
) (
    input  logic            clk,
    input  logic            rst_n,
    output logic [XLEN-1:0] imem_addr,
    input  logic [XLEN-1:0] imem_rdata,   // combinational instruction memory
    output commit_t         commit,
    output logic            halted,
    output logic            illegal
);

    logic [XLEN-1:0] ir;
    ctrl_t           ctrl;
    logic            is_illegal;
    logic            is_ebreak;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic [XLEN-1:0] result;
    logic            pc_load;
    logic [XLEN-1:0] pc_target;
    logic [XLEN-1:0] pc;
    logic            advance;
    logic            pc_load_q;
    logic [XLEN-1:0] pc_target_q;
    logic            rf_wen;

    assign imem_addr = pc;
    assign rf_wen    = advance && ctrl.reg_wen;   // write back on the retire pulse

    rv_decoder u_decoder (
        .inst       (ir),
        .ctrl       (ctrl),
        .is_illegal (is_illegal),
        .is_ebreak  (is_ebreak)
    );

    rv_imm_gen u_imm_gen (
        .inst   (ir),
        .imm_op (ctrl.imm_op),
        .imm    (imm)
    );

    rv_regfile u_regfile (
        .clk    (clk),
        .rst_n  (rst_n),
        .raddr1 (ctrl.reg1_raddr),
        .raddr2 (ctrl.reg2_raddr),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data),
        .wen    (rf_wen),
        .waddr  (ctrl.reg_waddr),
        .wdata  (commit.wdata)      // latched result
    );

    rv_execute u_execute (
        .ctrl      (ctrl),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .imm       (imm),
        .pc        (pc),
        .result    (result),
        .pc_load   (pc_load),
        .pc_target (pc_target)
    );

    rv_pc_counter #(
        .RESET_PC (RESET_PC)
    ) u_pc_counter (
        .clk     (clk),
        .rst_n   (rst_n),
        .advance (advance),
        .load    (pc_load_q),
        .target  (pc_target_q),
        .pc      (pc)
    );

    rv_core_fsm u_fsm (
        .clk         (clk),
        .rst_n       (rst_n),
        .imem_rdata  (imem_rdata),
        .pc          (pc),
        .ctrl        (ctrl),
        .is_illegal  (is_illegal),
        .is_ebreak   (is_ebreak),
        .result      (result),
        .pc_load     (pc_load),
        .pc_target   (pc_target),
        .ir          (ir),
        .advance     (advance),
        .pc_load_q   (pc_load_q),
        .pc_target_q (pc_target_q),
        .commit      (commit),
        .halted      (halted),
        .illegal     (illegal)
    );

endmodule

// File: rv_decoder.sv
module rv_decoder import rv_pkg::*; (
    input  logic [XLEN-1:0] inst,         // instruction register
    output ctrl_t           ctrl,         // decoded controls
    output logic            is_illegal,   // unsupported encoding
    output logic            is_ebreak
);

    opcode_e               opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [REG_ADDR_W-1:0] rd;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic                  bad;

    assign opcode = opcode_e'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign rd     = inst[11:7];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];

    always_comb begin
        ctrl      = CTRL_NOP;
        bad       = 1'b0;
        is_ebreak = 1'b0;
        case (opcode)
            OPC_R: begin
                ctrl.reg_wen    = 1'b1;
                ctrl.reg_waddr  = rd;
                ctrl.reg1_raddr = rs1;
                ctrl.reg2_raddr = rs2;
                ctrl.alu_src    = SRC_REG;
                if (funct3 == F3_ADD_SUB) begin
                    ctrl.alu_op = (funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
                end else begin
                    bad = 1'b1;
                end
            end
            OPC_I: begin
                ctrl.reg_wen    = 1'b1;
                ctrl.reg_waddr  = rd;
                ctrl.reg1_raddr = rs1;
                ctrl.imm_op     = IMM_I;
                ctrl.alu_src    = SRC_IMM;
                bad             = (funct3 != F3_ADDI);   // only addi
            end
            OPC_B: begin
                ctrl.reg1_raddr = rs1;
                ctrl.reg2_raddr = rs2;
                ctrl.imm_op     = IMM_B;
                ctrl.alu_src    = SRC_REG;
                ctrl.alu_op     = ALU_SUB;               // nonzero difference means ne
                ctrl.branch     = 1'b1;
                bad             = (funct3 != F3_BNE);
            end
            OPC_STORE: begin
                // no data memory, nothing to do
            end
            OPC_JAL: begin
                ctrl.jump      = 1'b1;
                ctrl.reg_wen   = 1'b1;
                ctrl.reg_waddr = rd;
                ctrl.imm_op    = IMM_J;
                ctrl.alu_src   = SRC_FOUR_PC;            // link value
            end
            OPC_JALR: begin
                ctrl.jump       = 1'b1;
                ctrl.jalr       = 1'b1;
                ctrl.reg_wen    = 1'b1;
                ctrl.reg_waddr  = rd;
                ctrl.reg1_raddr = rs1;                   // base of the target
                ctrl.imm_op     = IMM_I;
                ctrl.alu_src    = SRC_FOUR_PC;
                bad             = (funct3 != F3_JALR);
            end
            OPC_LUI: begin
                ctrl.reg_wen   = 1'b1;
                ctrl.reg_waddr = rd;
                ctrl.imm_op    = IMM_U;
                ctrl.alu_src   = SRC_IMM;                // x0 + imm
            end
            OPC_AUIPC: begin
                ctrl.reg_wen   = 1'b1;
                ctrl.reg_waddr = rd;
                ctrl.imm_op    = IMM_U;
                ctrl.alu_src   = SRC_IMM_PC;
            end
            OPC_SYSTEM: begin
                if (inst == EBREAK_INST) begin
                    is_ebreak = 1'b1;
                end else begin
                    bad = 1'b1;                          // ecall, csr ops
                end
            end
            default: begin
                bad = 1'b1;
            end
        endcase
        if (bad) begin
            ctrl = CTRL_NOP;                             // never leak a partial decode
        end
    end

    assign is_illegal = bad;

endmodule

// File: rv_execute.sv
module rv_execute import rv_pkg::*; (
    input  ctrl_t           ctrl,
    input  logic [XLEN-1:0] rs1_data,
    input  logic [XLEN-1:0] rs2_data,
    input  logic [XLEN-1:0] imm,
    input  logic [XLEN-1:0] pc,
    output logic [XLEN-1:0] result,      // alu output, also the link value
    output logic            pc_load,     // take pc_target instead of pc + 4
    output logic [XLEN-1:0] pc_target
);

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] jalr_sum;
    logic            taken;

    always_comb begin
        case (ctrl.alu_src)
            SRC_REG: begin
                op_a = rs1_data;
                op_b = rs2_data;
            end
            SRC_IMM: begin
                op_a = rs1_data;   // x0 for lui
                op_b = imm;
            end
            SRC_IMM_PC: begin
                op_a = pc;
                op_b = imm;
            end
            default: begin
                op_a = pc;
                op_b = XLEN'(4);
            end
        endcase
    end

    assign result = (ctrl.alu_op == ALU_SUB) ? op_a - op_b : op_a + op_b;

    // bne only, so a nonzero difference is taken
    assign taken    = ctrl.branch && (result != '0);
    assign pc_load  = ctrl.jump || taken;
    assign jalr_sum = rs1_data + imm;

    assign pc_target = ctrl.jalr ? {jalr_sum[XLEN-1:1], 1'b0} : pc + imm;

endmodule

// File: rv_imm_gen.sv
module rv_imm_gen import rv_pkg::*; (
    input  logic [XLEN-1:0] inst,
    input  imm_op_e         imm_op,   // format select from decoder
    output logic [XLEN-1:0] imm
);

    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_j;
    logic [XLEN-1:0] imm_u;

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};   // upper 20 bits

    always_comb begin
        case (imm_op)
            IMM_I:   imm = imm_i;
            IMM_B:   imm = imm_b;
            IMM_J:   imm = imm_j;
            IMM_U:   imm = imm_u;
            default: imm = imm_i;
        endcase
    end

endmodule

// File: rv_pc_counter.sv
module rv_pc_counter import rv_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = '0   // must be four-aligned
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            advance,   // one pulse per retired instruction
    input  logic            load,      // take target on advance
    input  logic [XLEN-1:0] target,
    output logic [XLEN-1:0] pc
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= RESET_PC;
        end else if (advance) begin
            pc <= load ? target : pc + XLEN'(4);
        end
    end

    // targets come from execute, misaligned ones would show up here
    pc_aligned: assert property (
        @(posedge clk) disable iff (!rst_n)
        pc[1:0] == 2'b00
    ) else $error("pc lost alignment: %h", pc);

endmodule

// File: rv_pkg.sv
package rv_pkg;

    localparam int XLEN       = 32;   // data and instruction width
    localparam int REG_ADDR_W = 5;    // register address width
    localparam int NUM_REGS   = 32;

    // major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        OPC_R      = 7'b0110011,
        OPC_I      = 7'b0010011,
        OPC_B      = 7'b1100011,
        OPC_STORE  = 7'b0100011,   // decoded as a no-op
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_ADDI    = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;
    localparam logic [2:0] F3_JALR    = 3'b000;
    localparam logic [6:0] F7_SUB     = 7'b0100000;   // any other funct7 is add

    localparam logic [XLEN-1:0] EBREAK_INST = 32'h0010_0073;

    typedef enum logic {
        ALU_ADD = 1'b0,
        ALU_SUB = 1'b1
    } alu_op_e;

    typedef enum logic [1:0] {
        IMM_I = 2'd0,
        IMM_B = 2'd1,
        IMM_J = 2'd2,
        IMM_U = 2'd3
    } imm_op_e;

    typedef enum logic [1:0] {
        SRC_REG     = 2'd0,   // rs1 op rs2
        SRC_IMM     = 2'd1,   // rs1 op imm
        SRC_IMM_PC  = 2'd2,   // pc op imm
        SRC_FOUR_PC = 2'd3    // pc + 4 for links
    } alu_src_e;

    typedef enum logic [1:0] {
        ST_FETCH = 2'd0,
        ST_EXEC  = 2'd1,
        ST_WB    = 2'd2,
        ST_HALT  = 2'd3
    } state_e;

    typedef struct packed {
        logic                  branch;
        logic                  jump;
        logic                  jalr;
        logic                  reg_wen;
        logic [REG_ADDR_W-1:0] reg_waddr;
        logic [REG_ADDR_W-1:0] reg1_raddr;
        logic [REG_ADDR_W-1:0] reg2_raddr;
        imm_op_e               imm_op;
        alu_op_e               alu_op;
        alu_src_e              alu_src;
    } ctrl_t;

    // safe defaults, no write and no pc change
    localparam ctrl_t CTRL_NOP = '{
        branch:     1'b0,
        jump:       1'b0,
        jalr:       1'b0,
        reg_wen:    1'b0,
        reg_waddr:  '0,
        reg1_raddr: '0,
        reg2_raddr: '0,
        imm_op:     IMM_I,
        alu_op:     ALU_ADD,
        alu_src:    SRC_REG
    };

    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       inst;
        logic                  wen;
        logic [REG_ADDR_W-1:0] waddr;
        logic [XLEN-1:0]       wdata;
    } commit_t;

endpackage

// File: rv_regfile.sv
module rv_regfile import rv_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [REG_ADDR_W-1:0] raddr1,
    input  logic [REG_ADDR_W-1:0] raddr2,
    output logic [XLEN-1:0]       rdata1,
    output logic [XLEN-1:0]       rdata2,
    input  logic                  wen,
    input  logic [REG_ADDR_W-1:0] waddr,
    input  logic [XLEN-1:0]       wdata
);

    logic [XLEN-1:0] regs [NUM_REGS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && (waddr != '0)) begin   // x0 is never written
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// File: tb_rv_core.sv
module tb_rv_core import rv_pkg::*;;

    localparam int               CLK_PERIOD   = 100;
    localparam int               RESET_CYCLES = 8;
    localparam int               RAND_LEN     = 200;
    localparam logic [XLEN-1:0]  RESET_PC     = 32'h0000_0100;

    logic            clk;
    logic            rst_n;
    logic [XLEN-1:0] imem_addr;
    logic [XLEN-1:0] imem_rdata;
    commit_t         commit;
    logic            halted;
    logic            illegal;

    logic [XLEN-1:0] prog [256];      // program image, word 0 at RESET_PC
    int              prog_len;
    logic [XLEN-1:0] ref_regs [32];   // reference architectural state
    logic [XLEN-1:0] ref_pc;
    commit_t         exp_q [$];       // expected commits of the current run
    commit_t         exp_c;
    logic            exp_illegal;
    logic [31:0]     rng;
    int              cycle;           // cycles since reset release
    int              last_commit;
    logic            halt_seen;
    logic            watch_on;
    time             deadline;

    rv_core_top #(
        .RESET_PC (RESET_PC)
    ) DUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .imem_addr  (imem_addr),
        .imem_rdata (imem_rdata),
        .commit     (commit),
        .halted     (halted),
        .illegal    (illegal)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] want);
        assert (got === want) else
            abort_run($sformatf("error at time %0t: %s is %h, expected %h",
                                $time, what, got, want));
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] mem_read(input logic [31:0] addr);
        logic [31:0] idx;
        idx = (addr - RESET_PC) >> 2;
        if ((addr < RESET_PC) || (idx >= 32'(prog_len))) begin
            return EBREAK_INST;   // outside the program
        end
        return prog[idx[7:0]];
    endfunction

    function automatic logic [31:0] add_sub(input logic sub, input logic [4:0] rd,
                                            input logic [4:0] rs1, input logic [4:0] rs2);
        return {(sub ? F7_SUB : 7'd0), rs2, rs1, 3'b000, rd, OPC_R};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] bne_inst(input logic [12:0] off, input logic [4:0] rs1,
                                             input logic [4:0] rs2);
        return {off[12], off[10:5], rs2, rs1, 3'b001, off[4:1], off[11], OPC_B};
    endfunction

    function automatic logic [31:0] jal_inst(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    // one instruction of the ISA model, updates ref_regs and ref_pc
    function automatic commit_t ref_step(input logic [31:0] inst, output logic halt,
                                         output logic bad);
        commit_t     c;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_b;
        logic [31:0] imm_j;
        logic [31:0] imm_u;
        logic [31:0] next_pc;
        logic [2:0]  f3;
        c       = '0;
        bad     = 1'b0;
        f3      = inst[14:12];
        a       = ref_regs[inst[19:15]];   // x0 is never written
        b       = ref_regs[inst[24:20]];
        imm_i   = {{20{inst[31]}}, inst[31:20]};
        imm_b   = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        imm_j   = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
        imm_u   = {inst[31:12], 12'd0};
        next_pc = ref_pc + 32'd4;
        c.valid = 1'b1;
        c.pc    = ref_pc;
        c.inst  = inst;
        c.waddr = inst[11:7];
        case (inst[6:0])
            OPC_R: begin
                bad     = (f3 != 3'b000);
                c.wen   = 1'b1;
                c.wdata = (inst[31:25] == 7'b0100000) ? a - b : a + b;
            end
            OPC_I: begin
                bad     = (f3 != 3'b000);   // addi only
                c.wen   = 1'b1;
                c.wdata = a + imm_i;
            end
            OPC_B: begin
                bad = (f3 != 3'b001);
                if (a != b) begin
                    next_pc = ref_pc + imm_b;
                end
            end
            OPC_STORE: ;                    // no data memory
            OPC_JAL: begin
                c.wen   = 1'b1;
                c.wdata = ref_pc + 32'd4;
                next_pc = ref_pc + imm_j;
            end
            OPC_JALR: begin
                bad     = (f3 != 3'b000);
                c.wen   = 1'b1;
                c.wdata = ref_pc + 32'd4;
                next_pc = (a + imm_i) & ~32'd1;
            end
            OPC_LUI: begin
                c.wen   = 1'b1;
                c.wdata = imm_u;
            end
            OPC_AUIPC: begin
                c.wen   = 1'b1;
                c.wdata = ref_pc + imm_u;
            end
            OPC_SYSTEM: bad = (inst != EBREAK_INST);
            default:    bad = 1'b1;
        endcase
        halt = bad || (inst == EBREAK_INST);
        if (!halt) begin
            if (c.wen && (c.waddr != 5'd0)) begin
                ref_regs[c.waddr] = c.wdata;
            end
            ref_pc = next_pc;
        end
        return c;
    endfunction

    task automatic append_inst(input logic [31:0] inst);
        prog[8'(prog_len)] = inst;
        prog_len = prog_len + 1;
    endtask

    task automatic load_directed();
        prog_len = 0;
        append_inst(u_type(20'h12345, 5'd1, OPC_LUI));            // 0x100
        append_inst(u_type(20'hfffff, 5'd2, OPC_AUIPC));          // 0x104 negative offset
        append_inst(i_type(12'd3, 5'd0, 3'd0, 5'd3, OPC_I));      // 0x108 loop count
        append_inst(i_type(12'hfff, 5'd3, 3'd0, 5'd3, OPC_I));    // 0x10c x3 -= 1
        append_inst(bne_inst(13'h1ffc, 5'd3, 5'd0));              // 0x110 back to 0x10c
        append_inst(jal_inst(21'd12, 5'd4));                      // 0x114 to 0x120
        append_inst(i_type(12'd9, 5'd0, 3'd0, 5'd7, OPC_I));      // skipped
        append_inst(i_type(12'd9, 5'd0, 3'd0, 5'd7, OPC_I));      // skipped
        append_inst(i_type(12'h128, 5'd0, 3'd0, 5'd5, OPC_I));    // 0x120 jalr base
        append_inst(i_type(12'd5, 5'd5, 3'd0, 5'd6, OPC_JALR));   // 0x12d, lands on 0x12c
        append_inst(i_type(12'd9, 5'd0, 3'd0, 5'd7, OPC_I));      // skipped
        append_inst({7'd0, 5'd1, 5'd2, 3'b010, 5'd0, OPC_STORE}); // sw as a no-op
        append_inst(add_sub(1'b1, 5'd0, 5'd6, 5'd1));             // write to x0
        append_inst(add_sub(1'b0, 5'd8, 5'd0, 5'd4));             // x0 still reads zero
        append_inst(EBREAK_INST);
    endtask

    task automatic load_random(input int count);
        int kind;
        prog_len = 0;
        for (int n = 0; n < count; n++) begin
            rng  = xorshift(rng);
            kind = int'(rng % 32'd3);
            if (kind == 2) begin
                append_inst(i_type(rng[31:20], {2'b00, rng[13:11]}, 3'd0,
                                   {2'b00, rng[10:8]}, OPC_I));
            end else begin
                append_inst(add_sub(kind == 1, {2'b00, rng[10:8]}, {2'b00, rng[13:11]},
                                    {2'b00, rng[16:14]}));
            end
        end
        append_inst(EBREAK_INST);
    endtask

    task automatic predict_run();
        logic [31:0] inst;
        logic        halt;
        logic        bad;
        commit_t     c;
        int          steps;
        exp_q.delete();
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end
        ref_pc = RESET_PC;
        halt   = 1'b0;
        bad    = 1'b0;
        steps  = 0;
        while (!halt) begin
            inst = mem_read(ref_pc);
            c    = ref_step(inst, halt, bad);
            if (!halt) begin
                exp_q.push_back(c);
            end
            steps = steps + 1;
            assert (steps < 1000) else abort_run("reference model never reached a halt");
        end
        exp_illegal = bad;
    endtask

    task automatic run_program(input string name);
        predict_run();
        $display("running %s program, %0d commits expected", name, exp_q.size());
        @(posedge clk);
        #1;
        rst_n    = 1'b0;
        deadline = $time + ((exp_q.size() + 1) * 3 + RESET_CYCLES + 20) * CLK_PERIOD;
        watch_on = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        while (!halted) @(negedge clk);
        repeat (3) @(negedge clk);   // any late commit is flagged by the checker
        assert (exp_q.size() == 0) else
            abort_run($sformatf("core halted with %0d instructions not committed",
                                exp_q.size()));
        check_value("illegal", 32'(illegal), 32'(exp_illegal));
        watch_on = 1'b0;
    endtask

    // memory answers 1 time unit after each rising edge
    initial begin
        imem_rdata = EBREAK_INST;
        forever begin
            @(posedge clk);
            #1;
            imem_rdata = mem_read(imem_addr);
        end
    end

    always @(negedge clk) begin
        if (!rst_n) begin
            cycle       = 0;
            last_commit = 0;
            halt_seen   = 1'b0;
            assert (!commit.valid && !halted && !illegal) else
                abort_run("core reports a commit or a halt while in reset");
            check_value("pc in reset", imem_addr, RESET_PC);
        end else begin
            cycle = cycle + 1;
            if (commit.valid) begin
                assert (exp_q.size() != 0) else
                    abort_run($sformatf("error at time %0t: unexpected commit at pc %h",
                                        $time, commit.pc));
                exp_c = exp_q.pop_front();
                check_value("commit cycle", cycle, last_commit + 3);
                check_value("commit pc", commit.pc, exp_c.pc);
                check_value("commit inst", commit.inst, exp_c.inst);
                check_value("commit wen", 32'(commit.wen), 32'(exp_c.wen));
                if (exp_c.wen) begin
                    check_value("commit waddr", 32'(commit.waddr), 32'(exp_c.waddr));
                    check_value("commit wdata", commit.wdata, exp_c.wdata);
                end
                last_commit = cycle;
            end
            if (halted && !halt_seen) begin
                halt_seen = 1'b1;
                check_value("halt cycle", cycle, last_commit + 3);   // one cycle after EXEC
            end
        end
    end

    initial begin
        forever begin
            @(posedge clk);
            if (watch_on && ($time > deadline)) begin
                abort_run("watchdog expired, the core did not halt in time");
            end
        end
    end

    initial begin
        rst_n    = 1'b1;   // first reset gives a real falling edge
        watch_on = 1'b0;
        deadline = 0;
        rng      = 32'd15;
        load_directed();
        run_program("directed");
        prog_len = 0;
        append_inst(i_type(12'd5, 5'd0, 3'd0, 5'd1, OPC_I));
        append_inst({7'd0, 5'd2, 5'd1, 3'b001, 5'd3, OPC_R});   // sll is not supported
        run_program("illegal");
        load_random(RAND_LEN);
        run_program("random");   // also shows the restart at RESET_PC
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule
